// File: verilog/x86_lite_pkg.sv
package x86_lite_pkg;

    typedef logic [15:0] addr_t;   // Byte address
    typedef logic [15:0] word_t;   // Register value
    typedef logic [11:0] flags_t;

    // --------------------------------------------------
    // Flag bit positions, 8086 layout
    // --------------------------------------------------
    localparam int FLAG_CF = 0;
    localparam int FLAG_PF = 2;
    localparam int FLAG_AF = 4;
    localparam int FLAG_ZF = 6;
    localparam int FLAG_SF = 7;
    localparam int FLAG_TF = 8;
    localparam int FLAG_IF = 9;
    localparam int FLAG_DF = 10;
    localparam int FLAG_OF = 11;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_OR,
        ALU_ADC,
        ALU_SBB,
        ALU_AND,
        ALU_SUB,
        ALU_XOR,
        ALU_CMP
    } alu_op_t;

    // Single-byte opcodes matched by value
    localparam logic [7:0] OP_HLT = 8'hF4;
    localparam logic [7:0] OP_CMC = 8'hF5;
    localparam logic [7:0] OP_CLC = 8'hF8;   // STC is OP_CLC | 1
    localparam logic [7:0] OP_CLI = 8'hFA;   // STI is OP_CLI | 1
    localparam logic [7:0] OP_CLD = 8'hFC;   // STD is OP_CLD | 1

    typedef struct packed {
        logic [7:0] data;
        addr_t      ip;
    } qbyte_t;

    typedef struct packed {
        addr_t      ip;
        logic [7:0] opcode;
        logic       reg_we;
        logic       reg_wide;
        logic [2:0] reg_idx;     // 8086 numbering
        word_t      reg_value;
        flags_t     flags;
        addr_t      next_ip;
    } retire_t;

    typedef struct packed {
        logic [31:0] araddr;
        logic [2:0]  arprot;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axi_r_t;

    localparam addr_t  RESET_IP    = 16'h0000;
    localparam flags_t RESET_FLAGS = 12'h002;   // Bit 1 reads as one

endpackage

// File: verilog/alu.sv
module alu (
    input  x86_lite_pkg::alu_op_t i_op,
    input  logic                  i_wide,
    input  x86_lite_pkg::word_t   i_op1,
    input  x86_lite_pkg::word_t   i_op2,
    input  x86_lite_pkg::flags_t  i_flags,
    output x86_lite_pkg::word_t   o_result,
    output x86_lite_pkg::flags_t  o_flags
);
    import x86_lite_pkg::*;

    word_t       a, b;
    logic [16:0] sum;   // One spare bit for carry or borrow
    logic [16:0] cin;
    logic        top_a, top_b, top_r;

    assign a     = i_wide ? i_op1 : {8'h00, i_op1[7:0]};
    assign b     = i_wide ? i_op2 : {8'h00, i_op2[7:0]};
    assign cin   = {16'h0000, i_flags[FLAG_CF]};
    assign top_a = i_wide ? a[15] : a[7];
    assign top_b = i_wide ? b[15] : b[7];
    assign top_r = i_wide ? o_result[15] : o_result[7];

    always_comb begin
        case (i_op)
            ALU_ADD: sum = {1'b0, a} + {1'b0, b};
            ALU_OR:  sum = {1'b0, a | b};
            ALU_ADC: sum = {1'b0, a} + {1'b0, b} + cin;
            ALU_SBB: sum = {1'b0, a} - {1'b0, b} - cin;
            ALU_AND: sum = {1'b0, a & b};
            ALU_XOR: sum = {1'b0, a ^ b};
            default: sum = {1'b0, a} - {1'b0, b};   // SUB and CMP
        endcase
        o_result = i_wide ? sum[15:0] : {8'h00, sum[7:0]};
    end

    always_comb begin
        o_flags          = i_flags;
        o_flags[FLAG_CF] = i_wide ? sum[16] : sum[8];
        o_flags[FLAG_AF] = a[4] ^ b[4] ^ o_result[4];
        case (i_op)
            ALU_ADD, ALU_ADC: o_flags[FLAG_OF] = (top_a ~^ top_b) & (top_a ^ top_r);
            ALU_SUB, ALU_SBB, ALU_CMP: o_flags[FLAG_OF] = (top_a ^ top_b) & (top_a ^ top_r);
            default: begin
                o_flags[FLAG_OF] = 1'b0;
                o_flags[FLAG_CF] = 1'b0;
                o_flags[FLAG_AF] = o_result[4];   // Logic ops keep result bit 4
            end
        endcase
        o_flags[FLAG_SF] = top_r;
        o_flags[FLAG_ZF] = (o_result == 16'h0000);
        o_flags[FLAG_PF] = ~^o_result[7:0];   // Low byte only
    end

endmodule

// File: verilog/fetch_unit.sv
module fetch_unit (
    input  logic                  clock,
    input  logic                  i_rst_n,
    output logic                  o_arvalid,
    output x86_lite_pkg::axi_ar_t o_ar,
    input  logic                  i_arready,
    input  logic                  i_rvalid,
    input  x86_lite_pkg::axi_r_t  i_r,
    output logic                  o_rready,
    output logic                  o_push,
    output x86_lite_pkg::qbyte_t  o_push_byte,
    input  logic                  i_full,
    input  logic                  i_redirect,
    input  x86_lite_pkg::addr_t   i_redirect_ip
);
    import x86_lite_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_AR, ST_R, ST_PUSH} fetch_state_t;

    fetch_state_t state;
    addr_t        fetch_ip;   // Address of the next byte to push
    addr_t        ar_addr;
    addr_t        start_ip;
    logic [31:0]  word_buf;
    logic         discard;    // Outstanding read went stale

    assign start_ip    = i_redirect ? i_redirect_ip : fetch_ip;
    assign o_arvalid   = (state == ST_AR);
    assign o_rready    = (state == ST_R);
    assign o_push      = (state == ST_PUSH);
    assign o_ar        = '{araddr: {16'h0000, ar_addr}, arprot: 3'b100};   // Instruction access
    assign o_push_byte = '{data: word_buf[{fetch_ip[1:0], 3'b000} +: 8], ip: fetch_ip};

    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= ST_IDLE;
            fetch_ip <= RESET_IP;
            ar_addr  <= '0;
            discard  <= 1'b0;
        end else begin
            if (i_redirect) fetch_ip <= i_redirect_ip;
            case (state)
                ST_IDLE: begin
                    state   <= ST_AR;
                    ar_addr <= {start_ip[15:2], 2'b00};
                end
                ST_AR: begin
                    if (i_redirect) discard <= 1'b1;   // Address must hold, so drop the data later
                    if (i_arready) state <= ST_R;
                end
                ST_R: begin
                    if (i_rvalid) begin
                        discard <= 1'b0;
                        if (discard || i_redirect) begin
                            state   <= ST_AR;
                            ar_addr <= {start_ip[15:2], 2'b00};
                        end else begin
                            state <= ST_PUSH;
                        end
                    end else if (i_redirect) begin
                        discard <= 1'b1;
                    end
                end
                default: begin
                    if (i_redirect) begin
                        state   <= ST_AR;
                        ar_addr <= {start_ip[15:2], 2'b00};
                    end else if (!i_full) begin
                        fetch_ip <= fetch_ip + 16'd1;
                        if (fetch_ip[1:0] == 2'b11) begin   // Last byte of the word
                            state   <= ST_AR;
                            ar_addr <= {fetch_ip[15:2] + 14'd1, 2'b00};
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == ST_R && i_rvalid) word_buf <= i_r.rdata;
    end

    // Request stays put until the memory takes it
    assert property (@(posedge clock) disable iff (!i_rst_n)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar));

endmodule

// File: verilog/prefetch_queue.sv
module prefetch_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                 clock,
    input  logic                 i_rst_n,
    input  logic                 i_push,
    input  x86_lite_pkg::qbyte_t i_push_byte,
    output logic                 o_full,
    output logic                 o_valid,
    output x86_lite_pkg::qbyte_t o_head,
    input  logic                 i_pop,
    input  logic                 i_flush
);
    import x86_lite_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    qbyte_t           mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign o_full  = count[PTR_W];   // Depth is a power of two
    assign o_valid = (count != '0);
    assign o_head  = mem[rd_ptr];
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && o_valid;

    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin   // Flush wins over push and pop
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) mem[wr_ptr] <= i_push_byte;
    end

    // A refused byte waits unchanged until there is room or a flush
    assert property (@(posedge clock) disable iff (!i_rst_n)
        i_push && o_full && !i_flush |=> i_flush || (i_push && $stable(i_push_byte)));

    assert property (@(posedge clock) disable iff (!i_rst_n) i_pop |-> o_valid);

endmodule

// File: verilog/exec_unit.sv
module exec_unit (
    input  logic                  clock,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  x86_lite_pkg::qbyte_t  i_head,
    output logic                  o_pop,
    output logic                  o_redirect,
    output x86_lite_pkg::addr_t   o_redirect_ip,
    output logic                  o_retire_valid,
    output x86_lite_pkg::retire_t o_retire,
    output logic                  o_halted
);
    import x86_lite_pkg::*;

    typedef enum logic [1:0] {S_OPC, S_MODRM, S_IMM_LO, S_IMM_HI} seq_t;

    seq_t       state;
    logic [7:0] opcode;
    logic [7:0] imm_lo;
    addr_t      ip;        // Address of the next byte expected
    addr_t      inst_ip;
    word_t      regs [8];
    flags_t     flags;

    logic [7:0] b, opc, cond;
    logic       is_alu_rm, is_alu_imm, is_incdec, is_mov, is_jcc;
    logic       wide, last, taken, wb_we;
    logic [2:0] dst_idx, src_idx, wb_idx;
    alu_op_t    aop;
    word_t      op1, op2, imm, alu_res, wb_value;
    flags_t     alu_flags, new_flags;
    addr_t      start_ip, next_ip;

    function automatic word_t read_reg(input logic [2:0] idx, input logic w);
        word_t r;
        r = regs[idx[1:0]];
        if (w) return regs[idx];
        return idx[2] ? {8'h00, r[15:8]} : {8'h00, r[7:0]};   // AH..BH share AX..BX
    endfunction

    assign b          = i_head.data;
    assign opc        = (state == S_OPC) ? b : opcode;
    assign start_ip   = (state == S_OPC) ? ip : inst_ip;
    assign is_alu_rm  = (opc[7:6] == 2'b00) && !opc[2];
    assign is_alu_imm = (opc[7:6] == 2'b00) && (opc[2:1] == 2'b10);
    assign is_incdec  = (opc[7:4] == 4'b0100);
    assign is_mov     = (opc[7:4] == 4'b1011);
    assign is_jcc     = (opc[7:4] == 4'b0111);
    assign wide       = is_mov ? opc[3] : (is_incdec | opc[0]);
    assign imm        = wide ? {b, imm_lo} : {8'h00, b};
    // ModRM mod bits are ignored, every form runs as reg,reg
    assign dst_idx    = opc[1] ? b[5:3] : b[2:0];
    assign src_idx    = opc[1] ? b[2:0] : b[5:3];
    assign o_pop      = i_valid && !o_halted && !o_redirect;

    // Jcc conditions indexed by opcode bits 3:1
    assign cond  = {(flags[FLAG_SF] ^ flags[FLAG_OF]) | flags[FLAG_ZF],
                    flags[FLAG_SF] ^ flags[FLAG_OF], flags[FLAG_PF], flags[FLAG_SF],
                    flags[FLAG_CF] | flags[FLAG_ZF], flags[FLAG_ZF], flags[FLAG_CF],
                    flags[FLAG_OF]};
    assign taken   = is_jcc && (cond[opc[3:1]] ^ opc[0]);
    assign next_ip = taken ? ip + 16'd1 + {{8{b[7]}}, b} : ip + 16'd1;

    always_comb begin
        case (state)
            S_OPC:    last = !(is_alu_rm | is_alu_imm | is_mov | is_jcc);
            S_IMM_LO: last = is_jcc | !wide;
            default:  last = 1'b1;
        endcase

        aop = alu_op_t'(opc[5:3]);
        op1 = read_reg(dst_idx, wide);
        op2 = read_reg(src_idx, wide);
        if (is_alu_imm) begin
            op1 = read_reg(3'd0, wide);
            op2 = imm;
        end else if (is_incdec) begin
            aop = opc[3] ? ALU_SUB : ALU_ADD;
            op1 = regs[opc[2:0]];
            op2 = 16'd1;
        end

        wb_we     = 1'b0;
        wb_idx    = dst_idx;
        wb_value  = alu_res;
        new_flags = flags;
        if (is_alu_rm || is_alu_imm) begin
            wb_we     = (aop != ALU_CMP);
            new_flags = alu_flags;
            if (is_alu_imm) wb_idx = 3'd0;   // AL or AX
        end else if (is_incdec) begin
            wb_we     = 1'b1;
            wb_idx    = opc[2:0];
            new_flags = {alu_flags[11:1], flags[FLAG_CF]};   // CF survives
        end else if (is_mov) begin
            wb_we    = 1'b1;
            wb_idx   = opc[2:0];
            wb_value = imm;
        end else begin
            case ({opc[7:1], 1'b0})
                OP_CLC:  new_flags[FLAG_CF] = opc[0];
                OP_CLI:  new_flags[FLAG_IF] = opc[0];
                OP_CLD:  new_flags[FLAG_DF] = opc[0];
                default: if (opc == OP_CMC) new_flags[FLAG_CF] = ~flags[FLAG_CF];
            endcase
        end
    end

    alu u_alu (
        .i_op     (aop),
        .i_wide   (wide),
        .i_op1    (op1),
        .i_op2    (op2),
        .i_flags  (flags),
        .o_result (alu_res),
        .o_flags  (alu_flags)
    );

    // --------------------------------------------------
    // Sequencer and architectural state
    // --------------------------------------------------
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state          <= S_OPC;
            ip             <= RESET_IP;
            flags          <= RESET_FLAGS;
            o_halted       <= 1'b0;
            o_retire_valid <= 1'b0;
            o_redirect     <= 1'b0;
            for (int i = 0; i < 8; i++) regs[i] <= '0;
        end else begin
            o_retire_valid <= 1'b0;
            o_redirect     <= 1'b0;
            if (o_pop && !last) begin
                ip    <= ip + 16'd1;
                state <= (state == S_OPC) ? (is_alu_rm ? S_MODRM : S_IMM_LO) : S_IMM_HI;
            end else if (o_pop) begin
                state          <= S_OPC;
                ip             <= next_ip;
                flags          <= new_flags;
                o_retire_valid <= 1'b1;
                o_redirect     <= taken;
                if (opc == OP_HLT) o_halted <= 1'b1;
                if (wb_we && wide) regs[wb_idx] <= wb_value;
                else if (wb_we && wb_idx[2]) regs[wb_idx[1:0]][15:8] <= wb_value[7:0];
                else if (wb_we) regs[wb_idx[1:0]][7:0] <= wb_value[7:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (o_pop && state == S_OPC) begin
            opcode  <= b;
            inst_ip <= ip;
        end
        if (o_pop && state == S_IMM_LO) imm_lo <= b;
        if (o_pop && last) begin
            o_redirect_ip <= next_ip;
            o_retire      <= '{ip: start_ip, opcode: opc, reg_we: wb_we,
                               reg_wide: wb_we & wide, reg_idx: wb_we ? wb_idx : 3'd0,
                               reg_value: wb_we ? wb_value : 16'h0000,
                               flags: new_flags, next_ip: next_ip};
        end
    end

    // Queue head must be the byte the sequencer is waiting for
    assert property (@(posedge clock) disable iff (!i_rst_n) o_pop |-> i_head.ip == ip);

endmodule

// File: verilog/x86_lite_top.sv
module x86_lite_top #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                  clock,
    input  logic                  i_rst_n,
    output logic                  o_arvalid,
    output x86_lite_pkg::axi_ar_t o_ar,
    input  logic                  i_arready,
    input  logic                  i_rvalid,
    input  x86_lite_pkg::axi_r_t  i_r,
    output logic                  o_rready,
    output logic                  o_retire_valid,
    output x86_lite_pkg::retire_t o_retire,
    output logic                  o_halted
);
    import x86_lite_pkg::*;

    logic   push, full, valid, pop, redirect;
    qbyte_t push_byte, head;
    addr_t  redirect_ip;

    fetch_unit u_fetch (
        .clock(clock), .i_rst_n(i_rst_n),
        .o_arvalid(o_arvalid), .o_ar(o_ar), .i_arready(i_arready),
        .i_rvalid(i_rvalid), .i_r(i_r), .o_rready(o_rready),
        .o_push(push), .o_push_byte(push_byte), .i_full(full),
        .i_redirect(redirect), .i_redirect_ip(redirect_ip)
    );

    // Redirect doubles as the queue flush
    prefetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_push(push), .i_push_byte(push_byte), .o_full(full),
        .o_valid(valid), .o_head(head), .i_pop(pop), .i_flush(redirect)
    );

    exec_unit u_exec (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_valid(valid), .i_head(head), .o_pop(pop),
        .o_redirect(redirect), .o_redirect_ip(redirect_ip),
        .o_retire_valid(o_retire_valid), .o_retire(o_retire), .o_halted(o_halted)
    );

endmodule

// File: tb/retire_checker.sv
module retire_checker #(
    parameter int MEM_AW = 9
) (
    input  logic                  clock,
    input  logic                  i_rst_n,
    input  logic                  i_retire_valid,
    input  x86_lite_pkg::retire_t i_retire,
    input  logic                  i_halted,
    input  logic [7:0]            i_prog [2**MEM_AW],
    output int                    o_value_errors,
    output int                    o_seq_errors,
    output int                    o_retires
);
    import x86_lite_pkg::*;

    addr_t   m_ip;        // Model state advanced once per retire
    word_t   m_regs [8];
    flags_t  m_flags;
    logic    hlt_seen;
    retire_t want;

    function automatic logic [7:0] mem_byte(input addr_t a);
        if (a[15:MEM_AW] != '0) return 8'hF4;   // HLT beyond the program array
        return i_prog[a[MEM_AW-1:0]];
    endfunction

    // 8-bit index 0..3 is AL..BL and 4..7 is AH..BH
    function automatic word_t get_reg(input logic [2:0] idx, input logic wide);
        word_t full;
        full = m_regs[{1'b0, idx[1:0]}];
        if (wide) return m_regs[idx];
        case (idx[2])
            1'b0:    return {8'h00, full[7:0]};
            default: return {8'h00, full[15:8]};
        endcase
    endfunction

    function automatic void set_reg(input logic [2:0] idx, input logic wide, input word_t v);
        if (wide) m_regs[idx] = v;
        else if (idx[2]) m_regs[{1'b0, idx[1:0]}][15:8] = v[7:0];
        else m_regs[{1'b0, idx[1:0]}][7:0] = v[7:0];
    endfunction

    // --------------------------------------------------
    // Arithmetic reference in plain integer math
    // --------------------------------------------------
    function automatic void alu_model(input logic [2:0] op, input logic wide, input word_t x,
                                      input word_t y, input flags_t f_in,
                                      output word_t res, output flags_t f_out);
        int   ua, ub, ur, lim;
        logic sx, sy, sr;
        lim = wide ? 'hFFFF : 'hFF;
        ua  = wide ? int'(x) : int'(x[7:0]);
        ub  = wide ? int'(y) : int'(y[7:0]);
        case (op)
            3'd0:    ur = ua + ub;
            3'd1:    ur = ua | ub;
            3'd2:    ur = ua + ub + int'(f_in[FLAG_CF]);
            3'd3:    ur = ua - ub - int'(f_in[FLAG_CF]);
            3'd4:    ur = ua & ub;
            3'd6:    ur = ua ^ ub;
            default: ur = ua - ub;   // SUB and CMP
        endcase
        res   = word_t'(ur & lim);
        sx    = wide ? x[15] : x[7];
        sy    = wide ? y[15] : y[7];
        sr    = wide ? res[15] : res[7];
        f_out = f_in;
        f_out[FLAG_CF] = (ur > lim) || (ur < 0);
        f_out[FLAG_AF] = ((ua ^ ub ^ ur) & 16) != 0;
        case (op)
            3'd0, 3'd2:       f_out[FLAG_OF] = (sx == sy) && (sr != sx);
            3'd3, 3'd5, 3'd7: f_out[FLAG_OF] = (sx != sy) && (sr != sx);
            default: begin
                f_out[FLAG_OF] = 1'b0;
                f_out[FLAG_CF] = 1'b0;
                f_out[FLAG_AF] = res[4];
            end
        endcase
        f_out[FLAG_SF] = sr;
        f_out[FLAG_ZF] = (res == 16'h0000);
        f_out[FLAG_PF] = ~^res[7:0];
    endfunction

    // Executes the instruction at m_ip and returns the record it should retire
    function automatic retire_t model_step();
        retire_t    e;
        logic [7:0] opc, b1, b2;
        logic [2:0] dst, src, widx;
        logic       wide, take, we;
        word_t      res, imm, wval;
        flags_t     nf;
        opc = mem_byte(m_ip);
        b1  = mem_byte(m_ip + 16'd1);
        b2  = mem_byte(m_ip + 16'd2);
        e   = '0;
        e.ip      = m_ip;
        e.opcode  = opc;
        e.flags   = m_flags;
        e.next_ip = m_ip + 16'd1;
        wide = opc[0];
        we   = 1'b0;
        widx = 3'd0;
        wval = 16'h0000;
        imm  = wide ? {b2, b1} : {8'h00, b1};
        if (opc[7:6] == 2'b00 && !opc[2]) begin   // reg,reg with ModRM
            dst = opc[1] ? b1[5:3] : b1[2:0];
            src = opc[1] ? b1[2:0] : b1[5:3];
            alu_model(opc[5:3], wide, get_reg(dst, wide), get_reg(src, wide), m_flags, res, nf);
            e.flags   = nf;
            e.next_ip = m_ip + 16'd2;
            we   = (opc[5:3] != 3'd7);
            widx = dst;
            wval = res;
        end else if (opc[7:6] == 2'b00 && opc[2:1] == 2'b10) begin   // AL/AX, imm
            alu_model(opc[5:3], wide, get_reg(3'd0, wide), imm, m_flags, res, nf);
            e.flags   = nf;
            e.next_ip = m_ip + (wide ? 16'd3 : 16'd2);
            we   = (opc[5:3] != 3'd7);
            wval = res;
        end else if (opc[7:4] == 4'h4) begin
            wide = 1'b1;   // Always a 16-bit register
            alu_model(opc[3] ? 3'd5 : 3'd0, wide, m_regs[opc[2:0]], 16'd1, m_flags, res, nf);
            nf[FLAG_CF] = m_flags[FLAG_CF];
            e.flags = nf;
            we   = 1'b1;
            widx = opc[2:0];
            wval = res;
        end else if (opc[7:4] == 4'hB) begin
            wide = opc[3];
            e.next_ip = m_ip + (wide ? 16'd3 : 16'd2);
            we   = 1'b1;
            widx = opc[2:0];
            wval = wide ? {b2, b1} : {8'h00, b1};
        end else if (opc[7:4] == 4'h7) begin
            case (opc[3:1])
                3'd0:    take = m_flags[FLAG_OF];
                3'd1:    take = m_flags[FLAG_CF];
                3'd2:    take = m_flags[FLAG_ZF];
                3'd3:    take = m_flags[FLAG_CF] || m_flags[FLAG_ZF];
                3'd4:    take = m_flags[FLAG_SF];
                3'd5:    take = m_flags[FLAG_PF];
                3'd6:    take = m_flags[FLAG_SF] != m_flags[FLAG_OF];
                default: take = m_flags[FLAG_ZF] || (m_flags[FLAG_SF] != m_flags[FLAG_OF]);
            endcase
            take = take ^ opc[0];   // Odd opcodes test the inverse
            e.next_ip = m_ip + 16'd2 + (take ? {{8{b1[7]}}, b1} : 16'h0000);
        end else begin
            case (opc)
                8'hF5:   e.flags[FLAG_CF] = ~m_flags[FLAG_CF];
                8'hF8:   e.flags[FLAG_CF] = 1'b0;
                8'hF9:   e.flags[FLAG_CF] = 1'b1;
                8'hFA:   e.flags[FLAG_IF] = 1'b0;
                8'hFB:   e.flags[FLAG_IF] = 1'b1;
                8'hFC:   e.flags[FLAG_DF] = 1'b0;
                8'hFD:   e.flags[FLAG_DF] = 1'b1;
                default: e.flags = m_flags;   // HLT and one-byte no-ops
            endcase
        end
        if (we) begin
            set_reg(widx, wide, wval);
            e.reg_we    = 1'b1;
            e.reg_wide  = wide;
            e.reg_idx   = widx;
            e.reg_value = wide ? wval : {8'h00, wval[7:0]};
        end
        m_flags = e.flags;
        m_ip    = e.next_ip;
        return e;
    endfunction

    task automatic compare_field(input string name, input logic [15:0] got,
                                 input logic [15:0] expv);
        if (got !== expv) begin
            $display("Fail o_retire.%s at ip %h: got %h, expected %h", name, want.ip, got, expv);
            o_value_errors++;
        end
    endtask

    // --------------------------------------------------
    // Compare at mid-cycle where outputs are settled
    // --------------------------------------------------
    always @(negedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            m_ip           = RESET_IP;
            m_flags        = RESET_FLAGS;
            m_regs         = '{default: '0};
            hlt_seen       = 1'b0;
            o_value_errors = 0;
            o_seq_errors   = 0;
            o_retires      = 0;
        end else begin
            if (i_retire_valid && hlt_seen) begin
                $display("Instruction at ip %h retired after the core halted", i_retire.ip);
                o_seq_errors++;
            end else if (i_retire_valid) begin
                want = model_step();
                compare_field("ip", i_retire.ip, want.ip);
                compare_field("opcode", {8'h00, i_retire.opcode}, {8'h00, want.opcode});
                compare_field("reg_we", {15'h0000, i_retire.reg_we}, {15'h0000, want.reg_we});
                compare_field("reg_wide", {15'h0000, i_retire.reg_wide},
                              {15'h0000, want.reg_wide});
                compare_field("reg_idx", {13'h0000, i_retire.reg_idx}, {13'h0000, want.reg_idx});
                compare_field("reg_value", i_retire.reg_value, want.reg_value);
                compare_field("flags", {4'h0, i_retire.flags}, {4'h0, want.flags});
                compare_field("next_ip", i_retire.next_ip, want.next_ip);
                hlt_seen = (want.opcode == 8'hF4);
                o_retires++;
            end
            if (i_halted !== hlt_seen) begin
                $display("Halt output disagrees with the model at ip %h", m_ip);
                o_seq_errors++;
            end
        end
    end

endmodule

// File: tb/tb_top.sv
module tb_top;
    import x86_lite_pkg::*;

    localparam int          QUEUE_DEPTH     = 8;
    localparam int          MEM_AW          = 9;
    localparam int          MEM_BYTES       = 1 << MEM_AW;
    localparam int          PROG_LEN        = 300;   // Random part, HLT after it
    localparam int          WATCHDOG_CYCLES = 30 * PROG_LEN;
    localparam int          QUIET_CYCLES    = 40;
    localparam logic [31:0] LFSR_SEED       = 32'h16b0e945;

    logic        clock;
    logic        rst_n;
    logic        arvalid, arready, rvalid, rready;
    axi_ar_t     ar;
    axi_r_t      r_beat;
    logic        retire_valid, halted;
    retire_t     retire;
    logic [7:0]  prog [MEM_BYTES];
    logic [31:0] lfsr_state;
    int          gen_pos;
    int          ar_cnt, r_cnt;   // Memory delays still to wait
    logic        r_busy;
    addr_t       r_addr;
    int          value_errors, seq_errors, retires;

    always #50 clock = ~clock;

    x86_lite_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut_i (
        .clock(clock), .i_rst_n(rst_n),
        .o_arvalid(arvalid), .o_ar(ar), .i_arready(arready),
        .i_rvalid(rvalid), .i_r(r_beat), .o_rready(rready),
        .o_retire_valid(retire_valid), .o_retire(retire), .o_halted(halted)
    );

    retire_checker #(.MEM_AW(MEM_AW)) checker_i (
        .clock(clock), .i_rst_n(rst_n),
        .i_retire_valid(retire_valid), .i_retire(retire), .i_halted(halted),
        .i_prog(prog), .o_value_errors(value_errors), .o_seq_errors(seq_errors),
        .o_retires(retires)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] prog_byte(input addr_t a);
        if (a[15:MEM_AW] != '0) return OP_HLT;
        return prog[a[MEM_AW-1:0]];
    endfunction

    task automatic emit(input logic [7:0] v);
        prog[gen_pos[MEM_AW-1:0]] = v;
        gen_pos++;
    endtask

    // --------------------------------------------------
    // Random program of kept instructions
    // --------------------------------------------------
    task automatic build_program();
        logic [31:0] r;
        logic [31:0] imm;
        for (int i = 0; i < MEM_BYTES; i++) prog[i[MEM_AW-1:0]] = OP_HLT;
        gen_pos = 0;
        while (gen_pos < PROG_LEN) begin
            r = take_bits(3);
            case (r[2:0])
                3'd0, 3'd1: begin   // ALU reg,reg, mod 11
                    r = take_bits(11);
                    emit({2'b00, r[2:0], 1'b0, r[4:3]});
                    emit({2'b11, r[10:5]});
                end
                3'd2: begin   // ALU accumulator, imm
                    r   = take_bits(4);
                    imm = take_bits(r[3] ? 16 : 8);
                    emit({2'b00, r[2:0], 2'b10, r[3]});
                    emit(imm[7:0]);
                    if (r[3]) emit(imm[15:8]);
                end
                3'd3: begin
                    r = take_bits(4);
                    emit({4'h4, r[3:0]});   // INC or DEC
                end
                3'd4: begin   // MOV reg, imm
                    r   = take_bits(4);
                    imm = take_bits(r[3] ? 16 : 8);
                    emit({4'hB, r[3:0]});
                    emit(imm[7:0]);
                    if (r[3]) emit(imm[15:8]);
                end
                3'd5, 3'd6: begin   // Jcc, forward 0..15
                    r = take_bits(8);
                    emit({4'h7, r[3:0]});
                    emit({4'h0, r[7:4]});
                end
                default: begin
                    r = take_bits(3);
                    emit((r[2:0] == 3'd0 || r[2:0] == 3'd7) ? 8'hF5 : 8'hF7 + {5'd0, r[2:0]});
                end
            endcase
        end
    endtask

    // --------------------------------------------------
    // AXI4-Lite read memory with random delays
    // --------------------------------------------------
    always @(posedge clock) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            r_busy  = 1'b0;
            ar_cnt  = 0;
        end else begin
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_busy = 1'b0;
                ar_cnt = int'(take_bits(2));
            end
            if (arready && arvalid) begin
                arready <= 1'b0;
                r_busy  = 1'b1;
                r_addr  = ar.araddr[15:0];
                r_cnt   = int'(take_bits(2));
            end else if (!r_busy && !arready) begin
                if (ar_cnt == 0) arready <= 1'b1;
                else ar_cnt--;
            end
            if (r_busy && !rvalid) begin
                if (r_cnt == 0) begin
                    rvalid <= 1'b1;
                    r_beat <= '{rdata: {prog_byte(r_addr + 16'd3), prog_byte(r_addr + 16'd2),
                                        prog_byte(r_addr + 16'd1), prog_byte(r_addr)},
                                rresp: 2'b00};
                end else begin
                    r_cnt--;
                end
            end
        end
    end

    initial begin
        clock      = 1'b0;
        rst_n      = 1'b0;
        arready    = 1'b0;
        rvalid     = 1'b0;
        r_beat     = '0;
        lfsr_state = LFSR_SEED;
        build_program();
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
        wait (halted);
        repeat (QUIET_CYCLES) @(posedge clock);   // Nothing may retire after HLT
        $display("Retired %0d instructions with %0d value errors and %0d sequence errors",
                 retires, value_errors, seq_errors);
        if (value_errors == 0 && seq_errors == 0 && retires > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Core did not halt within %0d cycles", WATCHDOG_CYCLES);
        $display("Retired %0d instructions with %0d value errors and %0d sequence errors",
                 retires, value_errors, seq_errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: x86_lite.f
verilog/x86_lite_pkg.sv
verilog/alu.sv
verilog/fetch_unit.sv
verilog/prefetch_queue.sv
verilog/exec_unit.sv
verilog/x86_lite_top.sv
tb/retire_checker.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f x86_lite.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
